/* verilog/hdmiPkg.sv */
// HDMI transmitter definitions
// Raster timing, island layout, symbol codes, AVI packet contents and shared types
package hdmiPkg;

	////////////////////////////////////////
	// Raster, 640x480p60 on an 800x525 grid
	localparam int displayWidth = 640;
	localparam int displayHeight = 480;
	localparam int fullWidth = 800;
	localparam int fullHeight = 525;
	localparam int hFrontPorch = 16;
	localparam int hSyncLen = 96;
	localparam int vFrontPorch = 10;
	localparam int vSyncLen = 2;

	// Data island placement within a line
	localparam int dataStart = 660;	// First column of the island preamble
	localparam int preambleLen = 8;
	localparam int guardLen = 2;
	localparam int packetLen = 32;
	localparam int videoPreambleStart = 790;

	////////////////////////////////////////
	// Control symbols, index is {c1, c0}
	localparam logic [3:0][9:0] ctrlCode = {10'b1010101011, 10'b0101010100,
		10'b0010101011, 10'b1101010100};

	// Video guard band per channel, index 0 is blue
	localparam logic [2:0][9:0] videoGuardCode = {10'b1011001100, 10'b0100110011,
		10'b1011001100};
	localparam logic [9:0] dataGuardCode = 10'b0100110011;

	// TERC4 symbols, 15 down to 0
	localparam logic [15:0][9:0] terc4Table = {
		10'b1011000011, 10'b0101100011, 10'b1001110001, 10'b1010001110,
		10'b1011000110, 10'b0110011100, 10'b0100111001, 10'b1011001100,
		10'b0100111100, 10'b0110001110, 10'b0100011110, 10'b0101110001,
		10'b1011100010, 10'b1011100100, 10'b1001100011, 10'b1010011100};

	////////////////////////////////////////
	// AVI InfoFrame packet
	localparam logic [23:0] aviHeader = 24'h0D0282;
	localparam logic [3:0][55:0] aviSubpacket = {56'h00000000000000, 56'h00000000000000,
		56'h0501000005bf00, 56'h0000010019107b};
	localparam logic [7:0] bchFeedback = 8'hC1;	// x^8 + x^7 + x^6 + 1

	// Shared types
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixelT;

	typedef struct packed {
		logic [9:0] red;
		logic [9:0] green;
		logic [9:0] blue;
	} symbolT;

	typedef enum logic [2:0] {ctrl, videoPre, videoGuard, video, dataPre, dataGuard,
		dataPayload} periodT;

	typedef struct packed {
		logic hSync;
		logic vSync;
		periodT period;
		logic payloadFirst;	// First cycle of the packet payload
	} ctrlT;

	typedef logic [23:0] headerT;
	typedef logic [55:0] subpacketT;

	typedef struct packed {
		logic [3:0] ch2;	// Red
		logic [3:0] ch1;	// Green
		logic [3:0] ch0;	// Blue
	} dataNibbleT;

endpackage

/* verilog/bchLane.sv */
// BCH protected payload lane
// Shifts a payload out LSB first, then its running parity MSB first
module bchLane #(
	parameter type payloadT = hdmiPkg::headerT,
	parameter int laneBits = 1
) (
	input logic pixclk,
	input logic load,
	input logic shift,
	input payloadT payload,
	output logic [laneBits-1:0] bits
);
	import hdmiPkg::*;

	localparam int payloadBits = $bits(payloadT);
	localparam int payloadCycles = payloadBits / laneBits;

	logic [payloadBits-1:0] shiftReg;
	logic [7:0] parity;
	logic [7:0] nextParity;
	logic [5:0] count;	// Cycles since load
	logic inPayload;

	assign inPayload = count < 6'(payloadCycles);

	// Parity over this cycle's data bits, lowest bit first
	always_comb
	begin
		nextParity = parity;
		for (int i = 0; i < laneBits; i++)
			nextParity = {nextParity[6:0], 1'b0}
				^ ((nextParity[7] ^ shiftReg[i]) ? bchFeedback : 8'h00);
	end

	always_comb
	begin
		for (int i = 0; i < laneBits; i++)
			bits[i] = inPayload ? shiftReg[i] : parity[7 - i];
	end

	always_ff @(posedge pixclk)
	begin
		if (load)
		begin
			shiftReg <= payload;
			parity <= 8'h00;
			count <= 6'd0;
		end
		else if (shift)
		begin
			if (inPayload)
			begin
				shiftReg <= shiftReg >> laneBits;
				parity <= nextParity;
			end
			else
				parity <= parity << laneBits;	// Parity goes out MSB first
			count <= count + 6'd1;
		end
	end

endmodule

/* verilog/channelEncoder.sv */
// TMDS channel encoder
// Video, TERC4, guard band or control coding chosen by line period, registered out
module channelEncoder #(
	parameter int channelIndex = 0	// 0 blue, 1 green, 2 red
) (
	input logic pixclk,
	input logic reset,
	input hdmiPkg::ctrlT ctrl,
	input logic [7:0] videoByte,
	input logic [3:0] nibble,
	output logic [9:0] symbol
);
	import hdmiPkg::*;

	logic [3:0] onesIn;
	logic [3:0] onesQm;
	logic useXnor;
	logic [8:0] qm;	// Transition minimized word
	logic signed [4:0] balance;	// Ones minus zeros in qm[7:0]
	logic signed [4:0] disparity;
	logic signed [4:0] nextDisparity;
	logic [9:0] tmdsCode;
	logic [1:0] ctrlPair;

	////////////////////////////////////////
	// Transition minimization
	always_comb
	begin
		onesIn = 4'd0;
		for (int i = 0; i < 8; i++)
			onesIn = onesIn + 4'(videoByte[i]);
		useXnor = (onesIn > 4'd4) || (onesIn == 4'd4 && !videoByte[0]);
		qm[0] = videoByte[0];
		for (int i = 1; i < 8; i++)
			qm[i] = useXnor ? !(qm[i-1] ^ videoByte[i]) : (qm[i-1] ^ videoByte[i]);
		qm[8] = !useXnor;
		onesQm = 4'd0;
		for (int i = 0; i < 8; i++)
			onesQm = onesQm + 4'(qm[i]);
		balance = $signed({onesQm, 1'b0}) - 5'sd8;
	end

	// DC balancing against the running disparity
	always_comb
	begin
		if (disparity == 5'sd0 || balance == 5'sd0)
		begin
			tmdsCode = {!qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
			nextDisparity = qm[8] ? disparity + balance : disparity - balance;
		end
		else if (disparity[4] == balance[4])
		begin
			tmdsCode = {1'b1, qm[8], ~qm[7:0]};	// Same sign, invert
			nextDisparity = disparity - balance + (qm[8] ? 5'sd2 : 5'sd0);
		end
		else
		begin
			tmdsCode = {1'b0, qm[8], qm[7:0]};
			nextDisparity = disparity + balance - (qm[8] ? 5'sd0 : 5'sd2);
		end
	end

	// Control pair, syncs on blue and preamble bits on green and red
	always_comb
	begin
		if (channelIndex == 0)
			ctrlPair = {ctrl.vSync, ctrl.hSync};
		else if (channelIndex == 1)
			ctrlPair = (ctrl.period == videoPre || ctrl.period == dataPre) ? 2'b01 : 2'b00;
		else
			ctrlPair = (ctrl.period == dataPre) ? 2'b01 : 2'b00;
	end

	////////////////////////////////////////
	always_ff @(posedge pixclk)
	begin
		if (reset)
		begin
			disparity <= 5'sd0;
			symbol <= ctrlCode[0];
		end
		else
		begin
			disparity <= (ctrl.period == video) ? nextDisparity : 5'sd0;
			case (ctrl.period)
				video: symbol <= tmdsCode;
				videoGuard: symbol <= videoGuardCode[channelIndex];
				dataGuard: symbol <= (channelIndex == 0) ? terc4Table[nibble] : dataGuardCode;
				dataPayload: symbol <= terc4Table[nibble];
				default: symbol <= ctrlCode[ctrlPair];	// Control and both preambles
			endcase
		end
	end

endmodule

/* verilog/packetSerializer.sv */
// AVI InfoFrame packet serializer
// Loads the packet before each island and emits three TERC4 data nibbles per cycle
module packetSerializer (
	input logic pixclk,
	input logic reset,
	input hdmiPkg::ctrlT ctrl,
	output hdmiPkg::dataNibbleT data
);
	import hdmiPkg::*;

	logic loaded;	// Packet taken for this island
	logic laneLoad;
	logic laneShift;
	logic headerBit;
	logic [1:0] subBits [4];	// Even bit in [0], odd bit in [1]

	////////////////////////////////////////
	// Load in the leading guard band, shift through the payload
	assign laneLoad = (ctrl.period == dataGuard) && !loaded;
	assign laneShift = ctrl.period == dataPayload;

	always_ff @(posedge pixclk)
	begin
		if (reset)
			loaded <= 1'b0;
		else if (laneLoad)
			loaded <= 1'b1;
		else if (ctrl.period == hdmiPkg::ctrl)
			loaded <= 1'b0;	// Rearm once the island is over
	end

	// Header lane, one bit per cycle plus 8 parity bits
	bchLane #(
		.payloadT(headerT),
		.laneBits(1)
	) headerLane (
		.pixclk,
		.load(laneLoad),
		.shift(laneShift),
		.payload(aviHeader),
		.bits(headerBit)
	);

	// Subpacket lanes, two bits per cycle
	for (genvar i = 0; i < 4; i++)
	begin : subLane
		bchLane #(
			.payloadT(subpacketT),
			.laneBits(2)
		) lane (
			.pixclk,
			.load(laneLoad),
			.shift(laneShift),
			.payload(aviSubpacket[i]),
			.bits(subBits[i])
		);
	end

	////////////////////////////////////////
	// Nibble assembly
	always_comb
	begin
		// Guard band pattern on channel 0, other channels idle
		data.ch0 = {1'b1, 1'b1, ctrl.vSync, ctrl.hSync};
		data.ch1 = 4'h0;
		data.ch2 = 4'h0;
		if (ctrl.period == dataPayload)
		begin
			data.ch0 = {!ctrl.payloadFirst, headerBit, ctrl.vSync, ctrl.hSync};
			for (int i = 0; i < 4; i++)
			begin
				data.ch1[i] = subBits[i][0];
				data.ch2[i] = subBits[i][1];
			end
		end
	end

endmodule

/* verilog/islandControl.sv */
// Raster timing and line period sequencing
// Counts columns and lines, decodes syncs and the period of each column
module islandControl (
	input logic pixclk,
	input logic reset,
	output hdmiPkg::ctrlT ctrl,
	output logic pixelReq
);
	import hdmiPkg::*;

	logic [9:0] column;
	logic [9:0] line;
	logic [9:0] islandOffset;	// Column relative to the island preamble
	logic visibleLine;
	logic nextLineVisible;
	logic inIsland;
	ctrlT nextCtrl;
	logic nextPixelReq;

	////////////////////////////////////////
	// Raster counters
	always_ff @(posedge pixclk)
	begin
		if (reset)
		begin
			column <= 10'd0;
			line <= 10'd0;
		end
		else if (column == 10'(fullWidth - 1))
		begin
			column <= 10'd0;
			line <= (line == 10'(fullHeight - 1)) ? 10'd0 : line + 10'd1;
		end
		else
			column <= column + 10'd1;
	end

	assign visibleLine = line < 10'(displayHeight);
	// Line 524 wraps to the first visible line
	assign nextLineVisible = (line < 10'(displayHeight - 1)) || (line == 10'(fullHeight - 1));

	assign islandOffset = column - 10'(dataStart);
	assign inIsland = (column >= 10'(dataStart))
		&& (islandOffset < 10'(preambleLen + 2 * guardLen + packetLen));

	////////////////////////////////////////
	// Period and sync decode
	always_comb
	begin
		nextCtrl.hSync = (column >= 10'(displayWidth + hFrontPorch))
			&& (column < 10'(displayWidth + hFrontPorch + hSyncLen));
		nextCtrl.vSync = (line >= 10'(displayHeight + vFrontPorch))
			&& (line < 10'(displayHeight + vFrontPorch + vSyncLen));
		nextCtrl.payloadFirst = inIsland && (islandOffset == 10'(preambleLen + guardLen));

		if (visibleLine && column < 10'(displayWidth))
			nextCtrl.period = video;
		else if (inIsland)
		begin
			if (islandOffset < 10'(preambleLen))
				nextCtrl.period = dataPre;
			else if (islandOffset < 10'(preambleLen + guardLen))
				nextCtrl.period = dataGuard;	// Leading guard band
			else if (islandOffset < 10'(preambleLen + guardLen + packetLen))
				nextCtrl.period = dataPayload;
			else
				nextCtrl.period = dataGuard;	// Trailing guard band
		end
		else if (column >= 10'(videoPreambleStart)
			&& column < 10'(videoPreambleStart + preambleLen))
			nextCtrl.period = videoPre;
		else if (column >= 10'(videoPreambleStart + preambleLen) && nextLineVisible)
			nextCtrl.period = videoGuard;
		else
			nextCtrl.period = hdmiPkg::ctrl;
	end

	// Request the pixel for the next column, one cycle ahead of its encode
	assign nextPixelReq = (visibleLine && column < 10'(displayWidth - 1))
		|| (column == 10'(fullWidth - 1) && nextLineVisible);

	always_ff @(posedge pixclk)
	begin
		if (reset)
		begin
			ctrl <= '{hSync: 1'b0, vSync: 1'b0, period: hdmiPkg::ctrl, payloadFirst: 1'b0};
			pixelReq <= 1'b0;
		end
		else
		begin
			ctrl <= nextCtrl;
			pixelReq <= nextPixelReq;
		end
	end

endmodule

/* verilog/hdmiTx.sv */
// HDMI source transmitter top
// Raster control, AVI packet serializer and three TMDS channel encoders
module hdmiTx (
	input logic pixclk,
	input logic reset,
	input hdmiPkg::pixelT pixel,
	output logic pixelReq,
	output hdmiPkg::symbolT symbols
);
	import hdmiPkg::*;

	ctrlT periodCtrl;	// Registered period and sync for the current column
	dataNibbleT packetData;
	logic [9:0] redSymbol;
	logic [9:0] greenSymbol;
	logic [9:0] blueSymbol;

	islandControl control (
		.pixclk,
		.reset,
		.ctrl(periodCtrl),
		.pixelReq
	);

	packetSerializer serializer (
		.pixclk,
		.reset,
		.ctrl(periodCtrl),
		.data(packetData)
	);

	////////////////////////////////////////
	// One encoder per TMDS channel
	channelEncoder #(.channelIndex(0)) blueEncoder (
		.pixclk,
		.reset,
		.ctrl(periodCtrl),
		.videoByte(pixel.blue),
		.nibble(packetData.ch0),
		.symbol(blueSymbol)
	);

	channelEncoder #(.channelIndex(1)) greenEncoder (
		.pixclk,
		.reset,
		.ctrl(periodCtrl),
		.videoByte(pixel.green),
		.nibble(packetData.ch1),
		.symbol(greenSymbol)
	);

	channelEncoder #(.channelIndex(2)) redEncoder (
		.pixclk,
		.reset,
		.ctrl(periodCtrl),
		.videoByte(pixel.red),
		.nibble(packetData.ch2),
		.symbol(redSymbol)
	);

	assign symbols = '{red: redSymbol, green: greenSymbol, blue: blueSymbol};

endmodule

/* sim/symbolChecker.sv */
// HDMI symbol checker
// Tracks the raster position at the symbols port and checks each symbol by the line rules
module symbolChecker (
	input logic pixclk,
	input logic reset,
	input hdmiPkg::pixelT pixel,
	input logic pixelReq,
	input hdmiPkg::symbolT symbols,
	input int testLine,
	input logic testVisible,
	output int testsDone,
	output int testsFailed,
	output int errorCount
);
	timeunit 1ns;
	timeprecision 1ps;
	import hdmiPkg::*;

	int edgeCount;	// Rising edges since reset release
	bit resetSeen;
	bit reqLast;
	bit reqOld;
	bit encodedValid;	// Pixel on the port at the last edge was requested
	pixelT encodedPixel;
	int lineErrors;
	int videoCount;	// Columns of the line fed from a requested pixel
	int disparity [3];
	logic [3:0] nibbles [3][32];	// Payload nibbles per channel with blue at 0

	////////////////////////////////////////
	// Reporting
	task automatic failure(input string what);
		$display("At %0d ns: %s", $time, what);
		lineErrors++;
		errorCount++;
	endtask

	task automatic compare(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("[ERROR] %0d ns %s: got %0h expected %0h", $time, name, got, expected);
			lineErrors++;
			errorCount++;
		end
	endtask

	task automatic expectSymbols(input logic [9:0] red, input logic [9:0] green,
		input logic [9:0] blue);
		compare("symbols.red", 64'(symbols.red), 64'(red));
		compare("symbols.green", 64'(symbols.green), 64'(green));
		compare("symbols.blue", 64'(symbols.blue), 64'(blue));
	endtask

	////////////////////////////////////////
	// Decoders and reference parity
	function automatic logic [7:0] tmdsDecode(input logic [9:0] sym);
		logic [7:0] q;
		logic [7:0] d;
		q = sym[9] ? ~sym[7:0] : sym[7:0];
		d[0] = q[0];
		for (int i = 1; i < 8; i++)
			d[i] = sym[8] ? (q[i] ^ q[i-1]) : !(q[i] ^ q[i-1]);	// Bit 8 set means XOR
		return d;
	endfunction

	function automatic int terc4Decode(input logic [9:0] sym);
		for (int n = 0; n < 16; n++)
			if (terc4Table[n] == sym)
				return n;
		return -1;
	endfunction

	function automatic logic [7:0] bchParity(input logic [55:0] data, input int count);
		logic [7:0] p;
		p = 8'h00;
		for (int n = 0; n < count; n++)
			p = {p[6:0], 1'b0} ^ ((p[7] ^ data[n]) ? bchFeedback : 8'h00);
		return p;
	endfunction

	////////////////////////////////////////
	// Packet rebuild from the payload nibbles
	task automatic checkPacket();
		logic [23:0] header;
		logic [7:0] headerParity;
		logic [55:0] sub;
		logic [7:0] subParity;
		for (int k = 0; k < packetLen; k++)
			if (k < 24)
				header[k] = nibbles[0][k][2];
			else
				headerParity[31 - k] = nibbles[0][k][2];	// Parity arrives MSB first
		compare("packet header", 64'(header), 64'(aviHeader));
		compare("packet header parity", 64'(headerParity),
			64'(bchParity(56'(aviHeader), 24)));
		for (int i = 0; i < 4; i++)
		begin
			for (int k = 0; k < packetLen; k++)
				if (k < 28)
				begin
					sub[2 * k] = nibbles[1][k][i];
					sub[2 * k + 1] = nibbles[2][k][i];
				end
				else
				begin
					subParity[63 - 2 * k] = nibbles[1][k][i];
					subParity[62 - 2 * k] = nibbles[2][k][i];
				end
			compare($sformatf("subpacket %0d", i), 64'(sub), 64'(aviSubpacket[i]));
			compare($sformatf("subpacket %0d parity", i), 64'(subParity),
				64'(bchParity(aviSubpacket[i], 56)));
		end
	endtask

	task automatic collectPayload(input int k, input logic [1:0] syncs);
		int code [3];
		code[0] = terc4Decode(symbols.blue);
		code[1] = terc4Decode(symbols.green);
		code[2] = terc4Decode(symbols.red);
		for (int c = 0; c < 3; c++)
		begin
			if (code[c] < 0)
				failure($sformatf("payload symbol on channel %0d is not a TERC4 code", c));
			nibbles[c][k] = 4'(code[c]);
		end
		compare("blue payload sync bits", 64'(nibbles[0][k][1:0]), 64'(syncs));
		compare("blue payload first flag", 64'(nibbles[0][k][3]), 64'(k != 0));
		if (k == packetLen - 1)
			checkPacket();
	endtask

	task automatic checkVideo(input int pos);
		logic [9:0] chan [3];
		// First column after reset has no request ahead of it
		if (!encodedValid && pos != 0)
			failure("video symbol encoded without a pixel request");
		compare("symbols.red decoded", 64'(tmdsDecode(symbols.red)), 64'(encodedPixel.red));
		compare("symbols.green decoded", 64'(tmdsDecode(symbols.green)),
			64'(encodedPixel.green));
		compare("symbols.blue decoded", 64'(tmdsDecode(symbols.blue)),
			64'(encodedPixel.blue));
		chan[0] = symbols.blue;
		chan[1] = symbols.green;
		chan[2] = symbols.red;
		for (int c = 0; c < 3; c++)
		begin
			disparity[c] += 2 * $countones(chan[c]) - 10;
			if (disparity[c] > 8 || disparity[c] < -8)
				failure($sformatf("running disparity on channel %0d reached %0d", c,
					disparity[c]));
		end
	endtask

	task automatic finishTest(input int line);
		if (videoCount != (testVisible ? displayWidth : 0))
		begin
			$display("[ERROR] %0d ns pixelReq count in line %0d: got %0d expected %0d", $time,
				line, videoCount, testVisible ? displayWidth : 0);
			lineErrors++;
			errorCount++;
		end
		testsDone++;
		if (lineErrors != 0)
			testsFailed++;
		$display("Test %0d, line %0d %s: %s with %0d errors", testsDone, line,
			testVisible ? "visible" : "blank", lineErrors == 0 ? "passed" : "failed", lineErrors);
	endtask

	////////////////////////////////////////
	// One symbol at raster position pos
	task automatic checkSymbol(input int pos);
		int column;
		int line;
		logic [1:0] syncs;
		column = pos % fullWidth;
		line = (pos / fullWidth) % fullHeight;
		syncs = {line >= 490 && line < 492, column >= 656 && column < 752};	// {vSync, hSync}
		if (column == 0)
		begin
			lineErrors = 0;
			videoCount = 0;
		end
		if (encodedValid || pos == 0)
			videoCount++;
		if (line < displayHeight && column < displayWidth)
			checkVideo(pos);
		else
		begin
			for (int c = 0; c < 3; c++)
				disparity[c] = 0;
			if (encodedValid)
				failure($sformatf("pixel requested for column %0d of line %0d", column, line));
			if (column >= 660 && column < 668)
				expectSymbols(ctrlCode[1], ctrlCode[1], ctrlCode[syncs]);	// Data preamble
			else if (column == 668 || column == 669 || column == 702 || column == 703)
				expectSymbols(dataGuardCode, dataGuardCode, terc4Table[{2'b11, syncs}]);
			else if (column >= 670 && column < 702)
				collectPayload(column - 670, syncs);
			else if (column >= 790 && column < 798)
				expectSymbols(ctrlCode[0], ctrlCode[1], ctrlCode[syncs]);	// Video preamble
			else if (column >= 798 && (line < displayHeight - 1 || line == fullHeight - 1))
				expectSymbols(videoGuardCode[2], videoGuardCode[1], videoGuardCode[0]);
			else
				expectSymbols(ctrlCode[0], ctrlCode[0], ctrlCode[syncs]);
		end
		if (column == fullWidth - 1 && line == testLine)
			finishTest(line);
	endtask

	always @(posedge pixclk)
	begin
		encodedPixel = pixel;
		encodedValid = reqOld;
		if (reset)
		begin
			edgeCount = 0;
			resetSeen = 1'b1;
		end
		else if (resetSeen)
			edgeCount = edgeCount + 1;
	end

	// Symbol for counter position X is on the port two edges later
	always @(negedge pixclk)
	begin
		reqOld = reqLast;
		reqLast = pixelReq;
		if (resetSeen && edgeCount < 2)
		begin
			expectSymbols(ctrlCode[0], ctrlCode[0], ctrlCode[0]);
			if (edgeCount == 0)
				compare("pixelReq", 64'(pixelReq), 64'(0));
		end
		else if (edgeCount >= 2)
			checkSymbol(edgeCount - 2);
	end

endmodule

/* sim/tbHdmiTx.sv */
// HDMI transmitter testbench
// Clock, reset, requested pixel source and a table of raster lines to check
module tbHdmiTx;
	timeunit 1ns;
	timeprecision 1ps;
	import hdmiPkg::*;

	typedef struct packed {
		logic [9:0] line;
		logic visible;
	} lineTestT;

	localparam int testCount = 10;
	localparam int waitLimit = 2 * fullWidth * fullHeight;	// Two frames per wait

	// Lines to check and whether each carries video
	localparam lineTestT tests [testCount] = '{
		'{10'd0, 1'b1}, '{10'd1, 1'b1}, '{10'd239, 1'b1}, '{10'd478, 1'b1},
		'{10'd479, 1'b1}, '{10'd480, 1'b0}, '{10'd489, 1'b0}, '{10'd490, 1'b0},
		'{10'd491, 1'b0}, '{10'd524, 1'b0}};

	logic pixclk;
	logic reset = 1'b1;
	pixelT pixel = '0;
	logic pixelReq;
	symbolT symbols;
	int seed = 61;
	bit reqPending;	// Request seen in the previous cycle
	int testLine;
	logic testVisible = 1'b1;
	int testsDone;
	int testsFailed;
	int errorCount;
	bit timedOut;

	hdmiTx dut (
		.pixclk,
		.reset,
		.pixel,
		.pixelReq,
		.symbols
	);

	symbolChecker symbolCheck (
		.pixclk,
		.reset,
		.pixel,
		.pixelReq,
		.symbols,
		.testLine,
		.testVisible,
		.testsDone,
		.testsFailed,
		.errorCount
	);

	initial
	begin
		pixclk = 1'b0;
		forever #2 pixclk = ~pixclk;
	end

	// New pixel in the cycle after each request
	always @(negedge pixclk)
	begin
		if (reqPending)
			pixel <= pixelT'(24'($random(seed)));
		reqPending <= pixelReq;
	end

	task automatic waitForTest(input int target);
		int cycles;
		cycles = 0;
		while (testsDone < target && cycles < waitLimit)
		begin
			@(posedge pixclk);
			cycles++;
		end
		if (testsDone < target)
		begin
			$display("Timed out after %0d cycles waiting for line %0d to finish", cycles, testLine);
			timedOut = 1'b1;
		end
	endtask

	////////////////////////////////////////
	initial
	begin
		testLine = int'(tests[0].line);
		repeat (16) @(negedge pixclk);
		reset = 1'b0;
		for (int i = 0; i < testCount && !timedOut; i++)
		begin
			testLine = int'(tests[i].line);
			testVisible = tests[i].visible;
			waitForTest(i + 1);
		end
		$display("Tests run %0d of %0d, failed %0d, check errors %0d", testsDone, testCount,
			testsFailed, errorCount);
		if (!timedOut && testsDone == testCount && testsFailed == 0 && errorCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* hdmiTx.f */
verilog/hdmiPkg.sv
verilog/bchLane.sv
verilog/channelEncoder.sv
verilog/packetSerializer.sv
verilog/islandControl.sv
verilog/hdmiTx.sv
sim/symbolChecker.sv
sim/tbHdmiTx.sv

/* run.sh */
#!/bin/sh
# Compile the HDMI transmitter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbHdmiTx -f hdmiTx.f -o simHdmiTx
./obj_dir/simHdmiTx > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log
then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
